/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;

    // op and op-imm
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // sub, sra, srai

    // one instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
    } rv_inst_t;

endpackage

`default_nettype wire

/* rtl/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // second alu operand
    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_S
    } op2_sel_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter int              XLEN      = 32,
    parameter logic [XLEN-1:0] EXIT_ADDR = 32'h40
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             branch_taken_i,
    input  wire [XLEN-1:0]  branch_target_i,
    output logic [XLEN-1:0] pc_o,
    output logic            halted_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    assign pc_next  = branch_taken_i ? branch_target_i : pc_q + XLEN'(4);
    assign halted_o = (pc_q == EXIT_ADDR);  // core parks here
    assign pc_o     = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!halted_o) begin
            pc_q <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_unit #(
    parameter int XLEN = 32
) (
    input  wire [31:0]              inst_i,
    output logic [4:0]              rs1_addr_o,
    output logic [4:0]              rs2_addr_o,
    output logic [4:0]              rd_addr_o,
    output logic [XLEN-1:0]         imm_i_o,
    output logic [XLEN-1:0]         imm_s_o,
    output logic [XLEN-1:0]         imm_b_o,
    output core_ctrl_pkg::alu_op_e  alu_op_o,
    output core_ctrl_pkg::op2_sel_e op2_sel_o,
    output core_ctrl_pkg::wb_sel_e  wb_sel_o,
    output logic                    rf_wen_o,
    output logic                    mem_wen_o,
    output logic                    is_branch_o,
    output logic [2:0]              br_funct3_o
);

    rv_isa_pkg::rv_inst_t   inst;
    core_ctrl_pkg::alu_op_e alu_f3;   // operation named by funct3
    logic                   is_op;
    logic                   f7_alt;
    logic                   f7_ok;    // funct7 legal for this funct3
    logic                   br_ok;

    assign inst = inst_i;

    assign rs1_addr_o  = inst.r.rs1;
    assign rs2_addr_o  = inst.r.rs2;
    assign rd_addr_o   = inst.r.rd;
    assign br_funct3_o = inst.b.funct3;

    assign imm_i_o = {{(XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    assign imm_s_o = {{(XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b_o = {{(XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                      inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};

    assign is_op  = (inst.r.opcode == rv_isa_pkg::OPC_OP);
    assign f7_alt = (inst.r.funct7 == rv_isa_pkg::F7_ALT);

    // op-imm only checks funct7 on shifts
    always_comb begin
        if (is_op) begin
            f7_ok = (inst.r.funct7 == rv_isa_pkg::F7_BASE) ||
                    (f7_alt && (inst.r.funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                inst.r.funct3 == rv_isa_pkg::F3_SRL_SRA));
        end else if (inst.r.funct3 == rv_isa_pkg::F3_SLL) begin
            f7_ok = (inst.r.funct7 == rv_isa_pkg::F7_BASE);
        end else if (inst.r.funct3 == rv_isa_pkg::F3_SRL_SRA) begin
            f7_ok = (inst.r.funct7 == rv_isa_pkg::F7_BASE) || f7_alt;
        end else begin
            f7_ok = 1'b1;
        end
    end

    always_comb begin
        case (inst.r.funct3)
            rv_isa_pkg::F3_ADD_SUB: begin
                alu_f3 = (is_op && f7_alt) ? core_ctrl_pkg::ALU_SUB : core_ctrl_pkg::ALU_ADD;
            end
            rv_isa_pkg::F3_SLL:     alu_f3 = core_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_f3 = core_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    alu_f3 = core_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     alu_f3 = core_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: begin
                alu_f3 = f7_alt ? core_ctrl_pkg::ALU_SRA : core_ctrl_pkg::ALU_SRL;
            end
            rv_isa_pkg::F3_OR:      alu_f3 = core_ctrl_pkg::ALU_OR;
            default:                alu_f3 = core_ctrl_pkg::ALU_AND;
        endcase
    end

    assign br_ok = inst.b.funct3 inside {rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE,
                                         rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BGE,
                                         rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU};

    always_comb begin
        alu_op_o    = core_ctrl_pkg::ALU_ADD;
        op2_sel_o   = core_ctrl_pkg::OP2_RS2;
        wb_sel_o    = core_ctrl_pkg::WB_ALU;
        rf_wen_o    = 1'b0;
        mem_wen_o   = 1'b0;
        is_branch_o = 1'b0;
        case (inst.r.opcode)
            rv_isa_pkg::OPC_LOAD: begin
                if (inst.i.funct3 == rv_isa_pkg::F3_LW) begin
                    op2_sel_o = core_ctrl_pkg::OP2_IMM_I;
                    wb_sel_o  = core_ctrl_pkg::WB_MEM;
                    rf_wen_o  = 1'b1;
                end
            end
            rv_isa_pkg::OPC_STORE: begin
                if (inst.s.funct3 == rv_isa_pkg::F3_SW) begin
                    op2_sel_o = core_ctrl_pkg::OP2_IMM_S;
                    mem_wen_o = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP: begin
                alu_op_o = alu_f3;
                rf_wen_o = f7_ok;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                alu_op_o  = alu_f3;
                op2_sel_o = core_ctrl_pkg::OP2_IMM_I;
                rf_wen_o  = f7_ok;
            end
            rv_isa_pkg::OPC_BRANCH: is_branch_o = br_ok;
            default: ;  // unknown word, no side effects
        endcase
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter int XLEN = 32
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    halted_i,
    input  wire [4:0]              rs1_addr_i,
    input  wire [4:0]              rs2_addr_i,
    input  wire [4:0]              rd_addr_i,
    input  wire                    rf_wen_i,
    input  var core_ctrl_pkg::wb_sel_e wb_sel_i,
    input  wire [XLEN-1:0]         alu_result_i,
    input  wire [XLEN-1:0]         mem_rdata_i,
    output logic [XLEN-1:0]        rs1_data_o,
    output logic [XLEN-1:0]        rs2_data_o
);

    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] wb_data;

    assign wb_data = (wb_sel_i == core_ctrl_pkg::WB_MEM) ? mem_rdata_i : alu_result_i;

    // x0 reads as zero whatever was written
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen_i && !halted_i) begin
            regs[rd_addr_i] <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit #(
    parameter int XLEN = 32
) (
    input  wire [XLEN-1:0]          rs1_data_i,
    input  wire [XLEN-1:0]          rs2_data_i,
    input  wire [XLEN-1:0]          imm_i_i,
    input  wire [XLEN-1:0]          imm_s_i,
    input  wire [XLEN-1:0]          imm_b_i,
    input  wire [XLEN-1:0]          pc_i,
    input  var core_ctrl_pkg::alu_op_e  alu_op_i,
    input  var core_ctrl_pkg::op2_sel_e op2_sel_i,
    input  wire                     is_branch_i,
    input  wire [2:0]               br_funct3_i,
    output logic [XLEN-1:0]         alu_result_o,
    output logic                    branch_taken_o,
    output logic [XLEN-1:0]         branch_target_o
);

    logic [XLEN-1:0] op2;
    logic [4:0]      shamt;
    logic            cond;

    always_comb begin
        case (op2_sel_i)
            core_ctrl_pkg::OP2_IMM_I: op2 = imm_i_i;
            core_ctrl_pkg::OP2_IMM_S: op2 = imm_s_i;
            default:                  op2 = rs2_data_i;
        endcase
    end

    assign shamt = op2[4:0];

    always_comb begin
        case (alu_op_i)
            core_ctrl_pkg::ALU_ADD:  alu_result_o = rs1_data_i + op2;
            core_ctrl_pkg::ALU_SUB:  alu_result_o = rs1_data_i - op2;
            core_ctrl_pkg::ALU_AND:  alu_result_o = rs1_data_i & op2;
            core_ctrl_pkg::ALU_OR:   alu_result_o = rs1_data_i | op2;
            core_ctrl_pkg::ALU_XOR:  alu_result_o = rs1_data_i ^ op2;
            core_ctrl_pkg::ALU_SLL:  alu_result_o = rs1_data_i << shamt;
            core_ctrl_pkg::ALU_SRL:  alu_result_o = rs1_data_i >> shamt;
            core_ctrl_pkg::ALU_SRA:  alu_result_o = $signed(rs1_data_i) >>> shamt;
            core_ctrl_pkg::ALU_SLT: begin
                alu_result_o = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(op2)};
            end
            core_ctrl_pkg::ALU_SLTU: alu_result_o = {{(XLEN-1){1'b0}}, rs1_data_i < op2};
            default:                 alu_result_o = '0;
        endcase
    end

    // branches compare the two registers directly
    always_comb begin
        case (br_funct3_i)
            rv_isa_pkg::F3_BEQ:  cond = (rs1_data_i == rs2_data_i);
            rv_isa_pkg::F3_BNE:  cond = (rs1_data_i != rs2_data_i);
            rv_isa_pkg::F3_BLT:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            rv_isa_pkg::F3_BGE:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            rv_isa_pkg::F3_BLTU: cond = (rs1_data_i < rs2_data_i);
            rv_isa_pkg::F3_BGEU: cond = (rs1_data_i >= rs2_data_i);
            default:             cond = 1'b0;
        endcase
    end

    assign branch_taken_o  = is_branch_i && cond;
    assign branch_target_o = pc_i + imm_b_i;

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
    parameter int              XLEN      = 32,
    parameter logic [XLEN-1:0] EXIT_ADDR = 32'h40
) (
    input  wire             clk,
    input  wire             rst_n,
    output logic [XLEN-1:0] imem_addr_o,
    input  wire [31:0]      imem_rdata_i,
    output logic [XLEN-1:0] dmem_addr_o,
    input  wire [XLEN-1:0]  dmem_rdata_i,
    output logic            dmem_wen_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    output logic            exit_o
);

    logic [4:0]               rs1_addr;
    logic [4:0]               rs2_addr;
    logic [4:0]               rd_addr;
    logic [XLEN-1:0]          imm_i;
    logic [XLEN-1:0]          imm_s;
    logic [XLEN-1:0]          imm_b;
    core_ctrl_pkg::alu_op_e   alu_op;
    core_ctrl_pkg::op2_sel_e  op2_sel;
    core_ctrl_pkg::wb_sel_e   wb_sel;
    logic                     rf_wen;
    logic                     mem_wen;
    logic                     is_branch;
    logic [2:0]               br_funct3;
    logic [XLEN-1:0]          rs1_data;
    logic [XLEN-1:0]          rs2_data;
    logic [XLEN-1:0]          alu_result;
    logic                     branch_taken;
    logic [XLEN-1:0]          branch_target;
    logic                     halted;

    fetch_unit #(
        .XLEN      (XLEN),
        .EXIT_ADDR (EXIT_ADDR)
    ) i_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pc_o            (imem_addr_o),
        .halted_o        (halted)
    );

    decode_unit #(.XLEN(XLEN)) i_decode (
        .inst_i      (imem_rdata_i),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rd_addr_o   (rd_addr),
        .imm_i_o     (imm_i),
        .imm_s_o     (imm_s),
        .imm_b_o     (imm_b),
        .alu_op_o    (alu_op),
        .op2_sel_o   (op2_sel),
        .wb_sel_o    (wb_sel),
        .rf_wen_o    (rf_wen),
        .mem_wen_o   (mem_wen),
        .is_branch_o (is_branch),
        .br_funct3_o (br_funct3)
    );

    reg_file #(.XLEN(XLEN)) i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .halted_i     (halted),
        .rs1_addr_i   (rs1_addr),
        .rs2_addr_i   (rs2_addr),
        .rd_addr_i    (rd_addr),
        .rf_wen_i     (rf_wen),
        .wb_sel_i     (wb_sel),
        .alu_result_i (alu_result),
        .mem_rdata_i  (dmem_rdata_i),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data)
    );

    exec_unit #(.XLEN(XLEN)) i_exec (
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .imm_i_i         (imm_i),
        .imm_s_i         (imm_s),
        .imm_b_i         (imm_b),
        .pc_i            (imem_addr_o),
        .alu_op_i        (alu_op),
        .op2_sel_i       (op2_sel),
        .is_branch_i     (is_branch),
        .br_funct3_i     (br_funct3),
        .alu_result_o    (alu_result),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    assign dmem_addr_o  = alu_result;     // lw/sw address is rs1 + imm
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = mem_wen && !halted;
    assign exit_o       = halted;

endmodule

`default_nettype wire

/* testbench/rv_core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker #(
    parameter int              XLEN      = 32,
    parameter logic [XLEN-1:0] EXIT_ADDR = 32'h40
) (
    input wire            clk,
    input wire            rst_n,
    input wire [XLEN-1:0] imem_addr_i,
    input wire            dmem_wen_i,
    input wire            exit_i,
    input wire [XLEN-1:0] branch_target_i
);

    int unsigned fail_count = 0;  // read by the testbench summary

    a_no_store_in_reset: assert property (@(posedge clk) !rst_n |-> (dmem_wen_i !== 1'b1))
        else begin
            fail_count++;
            $error("store enable seen while in reset");
        end

    // sequential or branch target, nothing else
    a_next_pc: assert property (@(posedge clk) disable iff (!rst_n)
            rst_n && !exit_i |=> (imem_addr_i == $past(imem_addr_i) + 32'd4) ||
                                 (imem_addr_i == $past(branch_target_i)))
        else begin
            fail_count++;
            $error("fetch address is neither pc+4 nor branch target");
        end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
            imem_addr_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("fetch address not word aligned");
        end

    a_exit_holds: assert property (@(posedge clk) disable iff (!rst_n)
            exit_i |=> exit_i && $stable(imem_addr_i))
        else begin
            fail_count++;
            $error("core left the exit state");
        end

    a_no_store_at_exit: assert property (@(posedge clk) disable iff (!rst_n)
            exit_i |-> !dmem_wen_i)
        else begin
            fail_count++;
            $error("store enable while halted");
        end

endmodule

bind rv_core rv_core_checker #(
    .XLEN      (XLEN),
    .EXIT_ADDR (EXIT_ADDR)
) i_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .imem_addr_i     (imem_addr_o),
    .dmem_wen_i      (dmem_wen_o),
    .exit_i          (exit_o),
    .branch_target_i (branch_target)
);

`default_nettype wire

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

    localparam logic [31:0] EXIT_ADDR = 32'h40;
    localparam logic [31:0] MARKER    = 32'hbad0_c0de;
    localparam logic [2:0]  OP_F3 [10] = '{rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F3_ADD_SUB,
        rv_isa_pkg::F3_AND, rv_isa_pkg::F3_OR, rv_isa_pkg::F3_XOR, rv_isa_pkg::F3_SLL,
        rv_isa_pkg::F3_SRL_SRA, rv_isa_pkg::F3_SRL_SRA, rv_isa_pkg::F3_SLT, rv_isa_pkg::F3_SLTU};
    localparam bit          OP_ALT [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
    localparam logic [2:0]  BR_F3 [6] = '{rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE,
        rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BGE, rv_isa_pkg::F3_BLTU, rv_isa_pkg::F3_BGEU};

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_rdata;
    logic        dmem_wen;
    logic [31:0] dmem_wdata;
    logic        exit_flag;

    rv_isa_pkg::rv_inst_t imem [256];
    logic [31:0]          dmem [256];
    logic [31:0]          exp_addr_q [$];
    logic [31:0]          exp_data_q [$];
    logic [31:0]          skip_q [$];   // slots behind taken branches
    int                   errors = 0;
    int                   pc_idx;
    int                   slot;
    integer               seed;

    rv_core #(.XLEN(32), .EXIT_ADDR(EXIT_ADDR)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_rdata_i (dmem_rdata),
        .dmem_wen_o   (dmem_wen),
        .dmem_wdata_o (dmem_wdata),
        .exit_o       (exit_flag)
    );

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic rv_isa_pkg::rv_inst_t r_type_word(input logic [6:0] f7,
            input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
            input logic [4:0] rd);
        rv_isa_pkg::rv_inst_t w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = rv_isa_pkg::OPC_OP;
        return w;
    endfunction

    function automatic rv_isa_pkg::rv_inst_t i_type_word(input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        rv_isa_pkg::rv_inst_t w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = opc;
        return w;
    endfunction

    function automatic rv_isa_pkg::rv_inst_t s_type_word(input logic [11:0] imm,
            input logic [4:0] rs2, input logic [4:0] rs1);
        rv_isa_pkg::rv_inst_t w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = rv_isa_pkg::F3_SW;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = rv_isa_pkg::OPC_STORE;
        return w;
    endfunction

    function automatic rv_isa_pkg::rv_inst_t b_type_word(input logic [12:0] imm,
            input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3);
        rv_isa_pkg::rv_inst_t w;
        w.b.imm_12   = imm[12];
        w.b.imm_10_5 = imm[10:5];
        w.b.rs2      = rs2;
        w.b.rs1      = rs1;
        w.b.funct3   = f3;
        w.b.imm_4_1  = imm[4:1];
        w.b.imm_11   = imm[11];
        w.b.opcode   = rv_isa_pkg::OPC_BRANCH;
        return w;
    endfunction

    // reference results straight from the ISA definitions
    function automatic logic [31:0] alu_expect(input logic [2:0] f3, input bit alt,
            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: r = alt ? x - y : x + y;
            rv_isa_pkg::F3_SLL:     r = x << y[4:0];
            rv_isa_pkg::F3_SLT:     r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            rv_isa_pkg::F3_SLTU:    r = (x < y) ? 32'd1 : 32'd0;
            rv_isa_pkg::F3_XOR:     r = x ^ y;
            rv_isa_pkg::F3_SRL_SRA: begin
                r = x >> y[4:0];
                if (alt && x[31]) r = r | ~(32'hffff_ffff >> y[4:0]);  // sign fill
            end
            rv_isa_pkg::F3_OR:      r = x | y;
            default:                r = x & y;
        endcase
        return r;
    endfunction

    function automatic bit branch_expect(input logic [2:0] f3, input logic [31:0] x,
            input logic [31:0] y);
        case (f3)
            rv_isa_pkg::F3_BEQ:  return x == y;
            rv_isa_pkg::F3_BNE:  return x != y;
            rv_isa_pkg::F3_BLT:  return $signed(x) < $signed(y);
            rv_isa_pkg::F3_BGE:  return !($signed(x) < $signed(y));
            rv_isa_pkg::F3_BLTU: return x < y;
            default:             return !(x < y);
        endcase
    endfunction

    task automatic put_inst(input rv_isa_pkg::rv_inst_t w);
        imem[pc_idx] = w;
        pc_idx++;
    endtask

    // sw rs into the next result slot
    task automatic store_reg(input logic [4:0] rs, input logic [31:0] value, input bit happens);
        put_inst(s_type_word(12'(slot), rs, 5'd0));
        if (happens) begin
            exp_addr_q.push_back(slot);
            exp_data_q.push_back(value);
        end else begin
            skip_q.push_back(slot);
        end
        slot += 4;
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] ea;
        logic [31:0] ed;
        assert (exp_addr_q.size() > 0) else begin
            $display("unexpected store of %h to address %h at %0t", data, addr, $time);
            errors++;
        end
        if (exp_addr_q.size() > 0) begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            assert (addr == ea) else begin
                $display("[FAIL] %0t dmem_addr_o: got %h, expected %h", $time, addr, ea);
                errors++;
            end
            assert (data == ed) else begin
                $display("[FAIL] %0t dmem_wdata_o: got %h, expected %h", $time, data, ed);
                errors++;
            end
        end
    endtask

    task automatic wait_for_exit(output bit reached);
        int cycles;
        cycles = 0;
        while (exit_flag !== 1'b1 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        reached = (exit_flag === 1'b1);
    endtask

    always @(posedge clk) begin
        if (dmem_wen === 1'b1) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            check_store(dmem_addr, dmem_wdata);
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] va;
        logic [31:0] vb;
        logic [11:0] imm;
        logic [4:0]  rs_a;
        logic [4:0]  rs_b;
        bit          reached;
        int          off;
        rst_n = 1'b0;
        seed  = 8205;
        for (int i = 0; i < 256; i++) begin
            imem[i] = i_type_word(12'(i), 5'd0, rv_isa_pkg::F3_ADD_SUB, 5'd0,
                                  rv_isa_pkg::OPC_OP_IMM);  // addi x0, x0, i
            dmem[i] = 32'h6b43_a9b5 ^ (i * 32'h0001_0003);
        end
        // a store parked at the exit address must never reach the bus
        imem[EXIT_ADDR[9:2]] = s_type_word(12'h3fc, 5'd3, 5'd0);
        a = $random(seed);
        b = $random(seed);
        if (b == a) b = ~a;
        dmem[0] = a;
        dmem[1] = b;
        dmem[2] = MARKER;
        slot    = 'h200;

        pc_idx = 0;
        put_inst(b_type_word(13'h80, 5'd0, 5'd0, rv_isa_pkg::F3_BEQ));  // hop over exit
        pc_idx = 32;
        put_inst(i_type_word(12'h000, 5'd0, rv_isa_pkg::F3_LW, 5'd1, rv_isa_pkg::OPC_LOAD));
        put_inst(i_type_word(12'h004, 5'd0, rv_isa_pkg::F3_LW, 5'd2, rv_isa_pkg::OPC_LOAD));
        put_inst(i_type_word(12'h008, 5'd0, rv_isa_pkg::F3_LW, 5'd3, rv_isa_pkg::OPC_LOAD));
        for (int k = 0; k < 10; k++) begin
            put_inst(r_type_word(OP_ALT[k] ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE,
                                 5'd2, 5'd1, OP_F3[k], 5'd4));
            store_reg(5'd4, alu_expect(OP_F3[k], OP_ALT[k], a, b), 1'b1);
        end
        for (int k = 0; k < 10; k++) begin
            if (!(OP_F3[k] == rv_isa_pkg::F3_ADD_SUB && OP_ALT[k])) begin  // no subi
                imm = 12'($random(seed));
                if (OP_F3[k] == rv_isa_pkg::F3_SLL || OP_F3[k] == rv_isa_pkg::F3_SRL_SRA) begin
                    imm = {(OP_ALT[k] ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE), imm[4:0]};
                end
                put_inst(i_type_word(imm, 5'd1, OP_F3[k], 5'd4, rv_isa_pkg::OPC_OP_IMM));
                store_reg(5'd4, alu_expect(OP_F3[k], OP_ALT[k], a, {{20{imm[11]}}, imm}), 1'b1);
            end
        end
        put_inst(r_type_word(rv_isa_pkg::F7_BASE, 5'd2, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd0));
        store_reg(5'd0, 32'd0, 1'b1);
        // a != b, so each pair gives one taken and one not taken
        for (int k = 0; k < 6; k++) begin
            for (int ord = 0; ord < 2; ord++) begin
                rs_a = (k < 2) ? 5'd1 : (ord == 0 ? 5'd1 : 5'd2);
                rs_b = (k < 2) ? (ord == 0 ? 5'd1 : 5'd2) : (ord == 0 ? 5'd2 : 5'd1);
                va   = (rs_a == 5'd1) ? a : b;
                vb   = (rs_b == 5'd1) ? a : b;
                put_inst(b_type_word(13'd8, rs_b, rs_a, BR_F3[k]));
                store_reg(5'd3, MARKER, !branch_expect(BR_F3[k], va, vb));
            end
        end
        off = EXIT_ADDR - pc_idx * 4;
        put_inst(b_type_word(13'(off), 5'd0, 5'd0, rv_isa_pkg::F3_BEQ));

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_for_exit(reached);
        if (!reached) begin
            $display("timeout: core never reached the exit address in the first run");
            errors++;
        end else begin
            assert (imem_addr == EXIT_ADDR) else begin
                $display("[FAIL] %0t imem_addr_o: got %h, expected %h", $time, imem_addr,
                         EXIT_ADDR);
                errors++;
            end
            repeat (4) @(posedge clk);
            foreach (skip_q[j]) begin
                assert (dmem[skip_q[j][9:2]] != MARKER) else begin
                    $display("[FAIL] %0t dmem[%h]: got %h, expected anything but %h", $time,
                             skip_q[j], dmem[skip_q[j][9:2]], MARKER);
                    errors++;
                end
            end
            assert (exp_addr_q.size() == 0) else begin
                $display("%0d expected stores never happened", exp_addr_q.size());
                errors++;
            end

            rst_n <= 1'b0;
            repeat (3) @(posedge clk);
            rst_n   <= 1'b1;
            imem[0] <= s_type_word(12'h300, 5'd3, 5'd0);  // x3 held the marker before reset
            exp_addr_q.push_back(32'h300);
            exp_data_q.push_back(32'd0);
            @(posedge clk);
            assert (imem_addr == 32'd0) else begin
                $display("[FAIL] %0t imem_addr_o: got %h, expected %h", $time, imem_addr, 0);
                errors++;
            end
            assert (exit_flag == 1'b0) else begin
                $display("[FAIL] %0t exit_o: got %b, expected %b", $time, exit_flag, 1'b0);
                errors++;
            end
            wait_for_exit(reached);
            if (!reached) begin
                $display("timeout: core never reached the exit address after reset");
                errors++;
            end
            assert (exp_addr_q.size() == 0) else begin
                $display("store after reset never happened");
                errors++;
            end
        end

        $display("errors: %0d, assertion failures: %0d", errors, i_dut.i_checker.fail_count);
        if (errors == 0 && i_dut.i_checker.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/rv_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/rv_core.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv
